/* logic/player_defines.svh */
`ifndef PLAYER_DEFINES_SVH
`define PLAYER_DEFINES_SVH

// ============================================================
// Data path widths
// ============================================================
`define PLAYER_SAMPLE_W 16  // One audio sample
`define PLAYER_WORD_W   32  // Flash word of two samples
`define PLAYER_ADDR_W   23  // Flash word address

// Last word of the sample region and wrap point in both directions
`define PLAYER_LAST_WORD 23'h7FFFF

// ============================================================
// Sample period in clk cycles
// ============================================================
`define PLAYER_PERIOD_W    16
`define PLAYER_BASE_PERIOD 64  // Scaled down for simulation
`define PLAYER_SPEED_STEP  8   // Change per speed event
`define PLAYER_MIN_PERIOD  32  // Fastest playback
`define PLAYER_MAX_PERIOD  128 // Slowest playback

`endif

/* logic/player_pkg.sv */
`include "player_defines.svh"

package player_pkg;

  // Playback commands from the keyboard
  typedef enum logic [2:0] {
    cmd_play,
    cmd_pause,
    cmd_forward,
    cmd_backward,
    cmd_restart
  } play_cmd_e;

  typedef enum logic [1:0] {st_idle, st_fetch, st_wait_done} play_state_e;

  typedef enum logic [2:0] {
    rd_idle,
    rd_read,
    rd_wait_data,
    rd_first,
    rd_second
  } reader_state_e;

  // ============================================================
  // Bundled signals
  // ============================================================
  typedef struct packed {logic valid; logic [7:0] ascii;} kbd_byte_t;
  typedef struct packed {logic faster; logic slower; logic restore;} speed_evt_t;

  typedef struct packed {
    logic                      valid;
    logic [`PLAYER_ADDR_W-1:0] addr;
    logic                      reverse; // High half goes out first
  } fetch_req_t;

  typedef struct packed {logic read; logic [`PLAYER_ADDR_W-1:0] addr;} flash_req_t;

  typedef struct packed {
    logic                      waitrequest;
    logic [`PLAYER_WORD_W-1:0] readdata;
    logic                      readdatavalid;
  } flash_rsp_t;

  typedef struct packed {logic valid; logic [`PLAYER_SAMPLE_W-1:0] sample;} audio_out_t;

endpackage

/* logic/key_command_decoder.sv */
`include "player_defines.svh"

module key_command_decoder (
  input  logic                  clk,
  input  logic                  reset,
  input  player_pkg::kbd_byte_t kbd,
  output player_pkg::play_cmd_e cmd,
  output logic                  cmd_valid
);

  player_pkg::play_cmd_e dec_cmd;
  logic                  dec_hit;

  // Letter match in either case
  always_comb begin
    dec_hit = 1'b1;
    dec_cmd = player_pkg::cmd_pause;
    case (kbd.ascii)
      8'h45, 8'h65: dec_cmd = player_pkg::cmd_play;     // E e
      8'h44, 8'h64: dec_cmd = player_pkg::cmd_pause;    // D d
      8'h46, 8'h66: dec_cmd = player_pkg::cmd_forward;  // F f
      8'h42, 8'h62: dec_cmd = player_pkg::cmd_backward; // B b
      8'h52, 8'h72: dec_cmd = player_pkg::cmd_restart;  // R r
      default:      dec_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= kbd.valid && dec_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (kbd.valid && dec_hit) begin
      cmd <= dec_cmd; // Held until the next accepted letter
    end
  end

endmodule

/* logic/sample_rate_ctrl.sv */
`include "player_defines.svh"

module sample_rate_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  player_pkg::speed_evt_t speed,
  output logic                   sample_tick
);

  localparam logic [`PLAYER_PERIOD_W-1:0] base_period = `PLAYER_BASE_PERIOD;
  localparam logic [`PLAYER_PERIOD_W-1:0] speed_step  = `PLAYER_SPEED_STEP;
  localparam logic [`PLAYER_PERIOD_W-1:0] min_period  = `PLAYER_MIN_PERIOD;
  localparam logic [`PLAYER_PERIOD_W-1:0] max_period  = `PLAYER_MAX_PERIOD;

  logic [`PLAYER_PERIOD_W-1:0] period_q; // Cycles between ticks
  logic [`PLAYER_PERIOD_W-1:0] count_q;

  // ============================================================
  // Period register
  // ============================================================
  // Restore wins over faster, faster wins over slower
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      period_q <= base_period;
    end else if (speed.restore) begin
      period_q <= base_period;
    end else if (speed.faster) begin
      if (period_q < min_period + speed_step) begin
        period_q <= min_period; // Clamp at fastest
      end else begin
        period_q <= period_q - speed_step;
      end
    end else if (speed.slower) begin
      if (period_q > max_period - speed_step) begin
        period_q <= max_period; // Clamp at slowest
      end else begin
        period_q <= period_q + speed_step;
      end
    end
  end

  // ============================================================
  // Tick generator
  // ============================================================
  // Counts period-1 down to zero, so ticks are exactly period_q apart.
  // The reload picks up whatever period is current at the tick.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count_q     <= base_period - 1'b1;
      sample_tick <= 1'b0;
    end else if (count_q == '0) begin
      count_q     <= period_q - 1'b1;
      sample_tick <= 1'b1;
    end else begin
      count_q     <= count_q - 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

/* logic/playback_addr_ctrl.sv */
`include "player_defines.svh"

module playback_addr_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  player_pkg::play_cmd_e  cmd,
  input  logic                   cmd_valid,
  input  logic                   word_done,
  output player_pkg::fetch_req_t fetch
);

  localparam logic [`PLAYER_ADDR_W-1:0] last_word = `PLAYER_LAST_WORD;

  player_pkg::play_state_e   state;
  logic                      playing;
  logic                      reverse;
  logic                      restart_pend;
  logic                      fetch_rev;   // Direction taken at fetch decision
  logic                      take_fetch;
  logic [`PLAYER_ADDR_W-1:0] addr;

  assign take_fetch = (state == player_pkg::st_idle) && playing;

  // ============================================================
  // Command flags
  // ============================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      playing      <= 1'b0;
      reverse      <= 1'b0;
      restart_pend <= 1'b0;
    end else begin
      if (take_fetch) begin
        restart_pend <= 1'b0; // Consumed by this fetch
      end
      if (cmd_valid) begin
        case (cmd)
          player_pkg::cmd_play:     playing      <= 1'b1;
          player_pkg::cmd_pause:    playing      <= 1'b0;
          player_pkg::cmd_forward:  reverse      <= 1'b0;
          player_pkg::cmd_backward: reverse      <= 1'b1;
          player_pkg::cmd_restart:  restart_pend <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // ============================================================
  // Fetch FSM and word address
  // ============================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= player_pkg::st_idle;
      addr      <= '0;
      fetch_rev <= 1'b0;
    end else begin
      case (state)
        player_pkg::st_idle: begin
          if (take_fetch) begin
            state     <= player_pkg::st_fetch;
            fetch_rev <= reverse;
            if (restart_pend) begin
              addr <= reverse ? last_word : '0; // Start of current direction
            end
          end
        end
        player_pkg::st_fetch: state <= player_pkg::st_wait_done;
        player_pkg::st_wait_done: begin
          if (word_done) begin
            state <= player_pkg::st_idle;
            if (reverse) begin
              addr <= (addr == '0) ? last_word : addr - 1'b1;
            end else begin
              addr <= (addr == last_word) ? '0 : addr + 1'b1;
            end
          end
        end
        default: state <= player_pkg::st_idle;
      endcase
    end
  end

  assign fetch.valid   = (state == player_pkg::st_fetch);
  assign fetch.addr    = addr;
  assign fetch.reverse = fetch_rev;

endmodule

/* logic/flash_sample_reader.sv */
`include "player_defines.svh"

module flash_sample_reader (
  input  logic                   clk,
  input  logic                   reset,
  input  player_pkg::fetch_req_t fetch,
  input  logic                   sample_tick,
  output player_pkg::flash_req_t flash_req,
  input  player_pkg::flash_rsp_t flash_rsp,
  output player_pkg::audio_out_t audio,
  output logic                   word_done
);

  player_pkg::reader_state_e    state;
  logic [`PLAYER_ADDR_W-1:0]    rd_addr;
  logic                         rd_rev;
  logic [`PLAYER_WORD_W-1:0]    data_q;
  logic                         audio_valid;
  logic [`PLAYER_SAMPLE_W-1:0]  sample_q;
  logic [`PLAYER_SAMPLE_W-1:0]  low_half;
  logic [`PLAYER_SAMPLE_W-1:0]  high_half;
  logic                         tick_first;
  logic                         tick_second;

  assign low_half    = data_q[`PLAYER_SAMPLE_W-1:0];
  assign high_half   = data_q[`PLAYER_WORD_W-1:`PLAYER_SAMPLE_W];
  assign tick_first  = (state == player_pkg::rd_first) && sample_tick;
  assign tick_second = (state == player_pkg::rd_second) && sample_tick;

  // ============================================================
  // Read handshake and sample sequencing
  // ============================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= player_pkg::rd_idle;
      audio_valid <= 1'b0;
      word_done   <= 1'b0;
    end else begin
      audio_valid <= 1'b0;
      word_done   <= 1'b0;
      case (state)
        player_pkg::rd_idle: begin
          if (fetch.valid) state <= player_pkg::rd_read;
        end
        player_pkg::rd_read: begin
          // Request accepted once waitrequest drops
          if (!flash_rsp.waitrequest) state <= player_pkg::rd_wait_data;
        end
        player_pkg::rd_wait_data: begin
          if (flash_rsp.readdatavalid) state <= player_pkg::rd_first;
        end
        player_pkg::rd_first: begin
          if (sample_tick) begin
            audio_valid <= 1'b1;
            state       <= player_pkg::rd_second;
          end
        end
        player_pkg::rd_second: begin
          if (sample_tick) begin
            audio_valid <= 1'b1;
            word_done   <= 1'b1; // Word finished with this sample
            state       <= player_pkg::rd_idle;
          end
        end
        default: state <= player_pkg::rd_idle;
      endcase
    end
  end

  // Address, word and sample payload
  always_ff @(posedge clk) begin
    if ((state == player_pkg::rd_idle) && fetch.valid) begin
      rd_addr <= fetch.addr;
      rd_rev  <= fetch.reverse;
    end
    if ((state == player_pkg::rd_wait_data) && flash_rsp.readdatavalid) begin
      data_q <= flash_rsp.readdata;
    end
    if (tick_first) sample_q <= rd_rev ? high_half : low_half;
    if (tick_second) sample_q <= rd_rev ? low_half : high_half;
  end

  assign flash_req.read = (state == player_pkg::rd_read); // Held until accepted
  assign flash_req.addr = rd_addr;
  assign audio.valid    = audio_valid;
  assign audio.sample   = sample_q;

endmodule

/* logic/audio_player_top.sv */
module audio_player_top (
  input  logic                   clk,
  input  logic                   reset,
  input  player_pkg::kbd_byte_t  kbd,
  input  player_pkg::speed_evt_t speed,
  output player_pkg::flash_req_t flash_req,
  input  player_pkg::flash_rsp_t flash_rsp,
  output player_pkg::audio_out_t audio
);

  player_pkg::play_cmd_e  cmd;
  logic                   cmd_valid;
  logic                   sample_tick;
  player_pkg::fetch_req_t fetch;
  logic                   word_done;

  // ============================================================
  // Input side
  // ============================================================
  key_command_decoder u_key_command_decoder (
    .clk       (clk),
    .reset     (reset),
    .kbd       (kbd),
    .cmd       (cmd),
    .cmd_valid (cmd_valid)
  );

  sample_rate_ctrl u_sample_rate_ctrl (
    .clk         (clk),
    .reset       (reset),
    .speed       (speed),
    .sample_tick (sample_tick)
  );

  // Address sequencing
  playback_addr_ctrl u_playback_addr_ctrl (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .word_done (word_done),
    .fetch     (fetch)
  );

  // Output side with flash port and samples
  flash_sample_reader u_flash_sample_reader (
    .clk         (clk),
    .reset       (reset),
    .fetch       (fetch),
    .sample_tick (sample_tick),
    .flash_req   (flash_req),
    .flash_rsp   (flash_rsp),
    .audio       (audio),
    .word_done   (word_done)
  );

endmodule

/* test/flash_mem_model.sv */
`include "player_defines.svh"

module flash_mem_model (
  input  logic                   clk,
  input  logic                   reset,
  input  player_pkg::flash_req_t flash_req,
  output player_pkg::flash_rsp_t flash_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [1:0] s_idle    = 2'd0;
  localparam logic [1:0] s_wait    = 2'd1;
  localparam logic [1:0] s_accept  = 2'd2;
  localparam logic [1:0] s_latency = 2'd3;

  logic [15:0]               lfsr = 16'd5;
  logic [1:0]                state;
  logic [2:0]                count;
  logic [`PLAYER_ADDR_W-1:0] addr_q;

  // Fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic logic [2:0] random_delay();
    logic [2:0] r;
    logic       fb;
    r = '0;
    for (int i = 0; i < 3; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[1:0], fb};
    end
    return r;
  endfunction

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      state                   <= s_idle;
      count                   <= '0;
      addr_q                  <= '0;
      flash_rsp.waitrequest   <= 1'b1;
      flash_rsp.readdatavalid <= 1'b0;
      flash_rsp.readdata      <= '0;
    end else begin
      flash_rsp.readdatavalid <= 1'b0;
      case (state)
        s_idle: begin
          if (flash_req.read) begin
            count <= random_delay(); // Wait states
            state <= s_wait;
          end
        end
        s_wait: begin
          if (count == '0) begin
            flash_rsp.waitrequest <= 1'b0; // Accept in the next cycle
            addr_q                <= flash_req.addr;
            state                 <= s_accept;
          end else begin
            count <= count - 1'b1;
          end
        end
        s_accept: begin
          flash_rsp.waitrequest <= 1'b1;
          count                 <= random_delay(); // Read latency
          state                 <= s_latency;
        end
        default: begin
          if (count == '0) begin
            flash_rsp.readdatavalid <= 1'b1;
            flash_rsp.readdata      <= {~addr_q[15:0], addr_q[15:0]};
            state                   <= s_idle;
          end else begin
            count <= count - 1'b1;
          end
        end
      endcase
    end
  end

endmodule

/* test/tb_audio_player.sv */
`include "player_defines.svh"

module tb_audio_player;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int planned_samples = 160;
  localparam int watchdog_cycles = planned_samples * `PLAYER_MAX_PERIOD * 2 + 1000;
  localparam logic [`PLAYER_ADDR_W-1:0] last_word = `PLAYER_LAST_WORD;

  logic                   clk;
  logic                   reset;
  player_pkg::kbd_byte_t  kbd;
  player_pkg::speed_evt_t speed;
  player_pkg::flash_req_t flash_req;
  player_pkg::flash_rsp_t flash_rsp;
  player_pkg::audio_out_t audio;

  // Reference model state
  logic                      m_playing, m_reverse, m_restart;
  logic [`PLAYER_ADDR_W-1:0] m_addr, exp_addr;
  logic                      exp_active, exp_rev, exp_half, word_end, interval_ok;
  int                        m_period, cycle_count, last_cycle, sample_count;
  int                        words_since, rand_gap, dir_idx;
  logic [15:0]               lfsr = 16'd5;
  logic                      has_cmd;
  logic [7:0]                letter;
  player_pkg::speed_evt_t    sp;

  // Directed opening of backward wrap, restart, forward wrap, pause and restart
  logic [7:0] dir_letter [5] = '{8'h62, 8'h52, 8'h46, 8'h64, 8'h72};
  int         dir_gap [5]    = '{3, 4, 3, 5, 3};

  audio_player_top u_audio_player_top (
    .clk(clk), .reset(reset), .kbd(kbd), .speed(speed),
    .flash_req(flash_req), .flash_rsp(flash_rsp), .audio(audio)
  );

  flash_mem_model u_flash_mem_model (
    .clk(clk), .reset(reset), .flash_req(flash_req), .flash_rsp(flash_rsp)
  );

  always #5 clk = ~clk;

  // Fibonacci LFSR stepped once for each bit taken
  function automatic logic [7:0] lfsr_bits(input int n);
    logic [7:0] r;
    logic       fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[6:0], fb};
    end
    return r;
  endfunction

  function automatic logic is_command(input logic [7:0] b);
    logic [7:0] u;
    u = b & 8'hDF; // Fold lower case onto upper case
    return (u == 8'h45) || (u == 8'h44) || (u == 8'h46) || (u == 8'h42) || (u == 8'h52);
  endfunction

  function automatic logic [7:0] random_letter();
    logic [7:0] pick;
    logic [7:0] lower;
    logic [7:0] code;
    pick  = lfsr_bits(3) % 5;
    lower = lfsr_bits(1);
    case (pick)
      8'd0:    code = 8'h45;
      8'd1:    code = 8'h44;
      8'd2:    code = 8'h46;
      8'd3:    code = 8'h42;
      default: code = 8'h52;
    endcase
    return lower[0] ? (code | 8'h20) : code;
  endfunction

  function automatic logic [`PLAYER_ADDR_W-1:0] next_addr(input logic [`PLAYER_ADDR_W-1:0] a,
                                                          input logic rev);
    if (rev) return (a == '0) ? last_word : a - 1'b1;
    return (a == last_word) ? '0 : a + 1'b1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR at %0t: %s expected %h actual %h", $time, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic apply_cmd(input logic [7:0] code);
    case (code & 8'hDF)
      8'h45:   m_playing = 1'b1;
      8'h44:   m_playing = 1'b0;
      8'h46:   m_reverse = 1'b0;
      8'h42:   m_reverse = 1'b1;
      8'h52:   m_restart = 1'b1;
      default: ;
    endcase
  endtask

  task automatic start_word();
    if (m_restart) begin
      m_addr    = m_reverse ? last_word : '0;
      m_restart = 1'b0;
    end
    exp_active = 1'b1;
    exp_addr   = m_addr;
    exp_rev    = m_reverse;
    exp_half   = 1'b0;
  endtask

  // A letter typed after word_done reaches the flags only after the next fetch decision
  task automatic decide_fetch(input logic cmd_sent, input logic [7:0] code);
    if (m_playing) begin
      start_word();
      if (cmd_sent) apply_cmd(code);
    end else begin
      if (cmd_sent) apply_cmd(code);
      if (m_playing) begin
        start_word();
        interval_ok = 1'b0; // Resume is not steady playback
      end
    end
  endtask

  task automatic update_period(input player_pkg::speed_evt_t ev);
    if (ev.restore) m_period = `PLAYER_BASE_PERIOD;
    else if (ev.faster) begin
      if (m_period < `PLAYER_MIN_PERIOD + `PLAYER_SPEED_STEP) m_period = `PLAYER_MIN_PERIOD;
      else m_period = m_period - `PLAYER_SPEED_STEP;
    end else if (ev.slower) begin
      if (m_period > `PLAYER_MAX_PERIOD - `PLAYER_SPEED_STEP) m_period = `PLAYER_MAX_PERIOD;
      else m_period = m_period + `PLAYER_SPEED_STEP;
    end
  endtask

  task automatic observe();
    logic [15:0] low_half;
    logic [15:0] exp_sample;
    cycle_count++;
    if (!exp_active) begin
      check_value("flash_req.read", 0, flash_req.read);
      check_value("audio.valid", 0, audio.valid);
    end else if (flash_req.read) begin
      check_value("flash_req.addr", exp_addr, flash_req.addr);
    end
    if (audio.valid) begin
      low_half   = exp_addr[15:0];
      exp_sample = (exp_rev ^ exp_half) ? ~low_half : low_half;
      check_value("audio.sample", exp_sample, audio.sample);
      if (interval_ok) check_value("sample interval", m_period, cycle_count - last_cycle);
      last_cycle  = cycle_count;
      interval_ok = 1'b1;
      sample_count++;
      if (exp_half) begin
        exp_active = 1'b0;
        word_end   = 1'b1;
        m_addr     = next_addr(m_addr, m_reverse);
      end else begin
        exp_half = 1'b1;
      end
    end
  endtask

  task automatic run_cycle(input logic kv, input logic [7:0] ch,
                           input player_pkg::speed_evt_t ev);
    @(posedge clk);
    kbd.valid <= kv;
    kbd.ascii <= ch;
    speed     <= ev;
    @(negedge clk); // Outputs settled
    observe();
  endtask

  // ============================================================
  // Stimulus
  // ============================================================
  initial begin
    clk = 1'b0;
    reset = 1'b1;
    kbd = '0;
    speed = '0;
    m_playing = 1'b0;
    m_reverse = 1'b0;
    m_restart = 1'b0;
    m_addr = '0;
    exp_addr = '0;
    exp_active = 1'b0;
    exp_rev = 1'b0;
    exp_half = 1'b0;
    word_end = 1'b0;
    interval_ok = 1'b0;
    m_period = `PLAYER_BASE_PERIOD;
    cycle_count = 0;
    last_cycle = 0;
    sample_count = 0;
    words_since = 0;
    rand_gap = 0;
    dir_idx = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // Stray bytes only while idle after reset
    repeat (40) begin
      letter = lfsr_bits(8);
      if (is_command(letter)) letter = letter ^ 8'h80;
      has_cmd = lfsr_bits(1);
      run_cycle(has_cmd, letter, '0);
    end

    while (sample_count < planned_samples) begin
      has_cmd = 1'b0;
      letter  = 8'h00;
      sp      = '0;
      if (word_end) begin
        word_end = 1'b0;
        words_since++;
        if (m_playing) begin
          if (dir_idx < 5) begin
            if (words_since >= dir_gap[dir_idx]) begin
              has_cmd = 1'b1;
              letter  = dir_letter[dir_idx];
              dir_idx++;
            end
          end else begin
            if (words_since >= rand_gap) begin
              has_cmd  = 1'b1;
              letter   = random_letter();
              rand_gap = lfsr_bits(2);
            end
            case (lfsr_bits(3))
              8'd0:    sp.faster = 1'b1;
              8'd1:    sp.slower = 1'b1;
              8'd2:    sp.restore = 1'b1;
              8'd3:    sp = '{faster: 1'b1, slower: 1'b1, restore: 1'b0};
              8'd4:    sp = '{faster: 1'b1, slower: 1'b0, restore: 1'b1};
              default: ;
            endcase
          end
          if (has_cmd) words_since = 0;
          if (sp != '0) begin
            update_period(sp);
            interval_ok = 1'b0;
          end
        end
        decide_fetch(has_cmd, letter);
        run_cycle(has_cmd, letter, sp);
      end else if (!m_playing && !exp_active) begin
        repeat (60) run_cycle(1'b0, 8'h00, '0); // Nothing may come out while paused
        letter = lfsr_bits(1) ? 8'h65 : 8'h45;
        decide_fetch(1'b1, letter);
        run_cycle(1'b1, letter, '0);
      end else begin
        run_cycle(1'b0, 8'h00, '0);
      end
    end

    $display("NO ERRORS");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: playback did not produce all planned samples in time");
    $display("ERRORS FOUND");
    $fatal(1);
  end

endmodule

/* compile.f */
+incdir+logic
logic/player_pkg.sv
logic/key_command_decoder.sv
logic/sample_rate_ctrl.sv
logic/playback_addr_ctrl.sv
logic/flash_sample_reader.sv
logic/audio_player_top.sv
test/flash_mem_model.sv
test/tb_audio_player.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the audio player testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module tb_audio_player -o sim_audio_player

./obj_dir/sim_audio_player > sim.log 2>&1 || true
cat sim.log

if grep -q "NO ERRORS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
